// ==== src/pcie_host_chan_pkg.sv ====
/* Widths and beat layouts shared by both sides of the host channel adapter.
   A header is assumed only in segment 0; the other segments carry payload only. */
`default_nettype none

package pcie_host_chan_pkg;

    // Stream data width of the PCIe subsystem ports
    localparam int TDATA_WIDTH = 256;

    // Number of subsystem segments in one beat
    localparam int NUM_SEG = 2;

    // Byte keep width, one bit per data byte
    localparam int KEEP_WIDTH = TDATA_WIDTH / 8;

    // Bytes per segment, also the stride to a segment's first keep bit
    localparam int SEG_BYTES = KEEP_WIDTH / NUM_SEG;

    // Dwords per beat, the granularity of subsystem keep masks
    localparam int NUM_DWORDS = TDATA_WIDTH / 32;

    // Width of the subsystem's vendor user bits
    localparam int VENDOR_WIDTH = 10;

    // Subsystem-side beat
    // Bit 0 of user_vendor selects the header format, 0 for PU and 1 for DM
    typedef struct packed {
        logic [TDATA_WIDTH-1:0]  data;
        logic [KEEP_WIDTH-1:0]   keep;
        logic                    last;
        logic [VENDOR_WIDTH-1:0] user_vendor;
    } pcie_ss_beat_t;

    // Platform-side user flags for one segment
    typedef struct packed {
        logic dm_mode;
        logic sop;
        logic eop;
    } host_seg_user_t;

    // Platform-side beat, with packet framing carried per segment in user
    typedef struct packed {
        logic [TDATA_WIDTH-1:0]         data;
        logic [KEEP_WIDTH-1:0]          keep;
        logic                           last;
        host_seg_user_t [NUM_SEG-1:0]   user;
    } host_beat_t;

endpackage

`default_nettype wire

// ==== src/host_chan_tx_map.sv ====
/* Platform TX stream to one subsystem TX port, purely combinational.
   Keep is reduced to dword granularity; only the lowest byte of each dword counts. */
`timescale 1ns/100ps
`default_nettype none

module host_chan_tx_map
(
    // Platform side
    input  wire pcie_host_chan_pkg::host_beat_t     in_beat,
    input  wire logic                               in_valid,
    output logic                                    in_ready,

    // Subsystem side
    output pcie_host_chan_pkg::pcie_ss_beat_t       out_beat,
    output logic                                    out_valid,
    input  wire logic                               out_ready
);

    import pcie_host_chan_pkg::*;

    // Handshake passes straight through with no buffering
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    always_comb
    begin
        // Payload and packet end pass through unchanged
        out_beat.data = in_beat.data;
        out_beat.last = in_beat.last;

        // The subsystem only masks whole dwords
        // Each dword takes its lowest byte keep bit on all four lanes
        for (int w = 0; w < NUM_DWORDS; w++)
        begin
            out_beat.keep[w*4 +: 4] = {4{in_beat.keep[w*4]}};
        end

        // Only segment 0 can hold a header, so its format flag is the one sent
        // The remaining vendor bits have no meaning on this path
        out_beat.user_vendor    = '0;
        out_beat.user_vendor[0] = in_beat.user[0].dm_mode;
    end

endmodule

`default_nettype wire

// ==== src/host_chan_rx_map.sv ====
/* Subsystem RX port to a platform RX stream with sop/eop framing in user.
   CPL_ONLY=1 assumes every beat is a whole header-only packet; no flow control added. */
`timescale 1ns/100ps
`default_nettype none

module host_chan_rx_map
#(
    // 0 for general traffic with sop tracking, 1 for header-only completions
    parameter bit CPL_ONLY = 1'b0
)
(
    input  wire logic                               clk,
    input  wire logic                               reset_n,

    // Subsystem side
    input  wire pcie_host_chan_pkg::pcie_ss_beat_t  in_beat,
    input  wire logic                               in_valid,
    output logic                                    in_ready,

    // Platform side
    output pcie_host_chan_pkg::host_beat_t          out_beat,
    output logic                                    out_valid,
    input  wire logic                               out_ready
);

    import pcie_host_chan_pkg::*;

    // Framing flags for segment 0, produced by the mode-specific logic below
    logic seg_sop;
    logic seg_eop;

    // Handshake passes straight through
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    generate
        if (CPL_ONLY)
        begin : g_cpl
            // Every completion is a single beat, so it starts and ends together
            assign seg_sop = in_beat.last;
            assign seg_eop = in_beat.last;
        end
        else
        begin : g_track
            logic sop_q;
            logic any_payload;

            // A new packet starts on the beat after a transferred last beat
            // Reset puts the channel at a packet boundary
            always_ff @(posedge clk)
            begin
                if (!reset_n)
                begin
                    sop_q <= 1'b1;
                end
                else if (in_valid && in_ready)
                begin
                    sop_q <= in_beat.last;
                end
            end

            // The last beat only marks eop when some segment holds data
            // Testing each segment's first keep bit is enough
            always_comb
            begin
                any_payload = 1'b0;
                for (int s = 0; s < NUM_SEG; s++)
                begin
                    any_payload = any_payload | in_beat.keep[s*SEG_BYTES];
                end
            end

            assign seg_sop = sop_q;
            assign seg_eop = in_beat.last & any_payload;
        end
    endgenerate

    always_comb
    begin
        // Payload, keep and last are carried across unchanged
        out_beat.data = in_beat.data;
        out_beat.keep = in_beat.keep;
        out_beat.last = in_beat.last;

        // All flags are zero outside segment 0, where the header sits
        out_beat.user            = '0;
        out_beat.user[0].dm_mode = in_beat.user_vendor[0];
        out_beat.user[0].sop     = seg_sop;
        out_beat.user[0].eop     = seg_eop;
    end

endmodule

`default_nettype wire

// ==== src/pcie_host_chan_map.sv ====
/* Host channel adapter between the PCIe subsystem and the platform streams.
   The four channels are independent; no ordering or arbitration between them. */
`timescale 1ns/100ps
`default_nettype none

module pcie_host_chan_map
(
    input  wire logic                               clk,
    input  wire logic                               reset_n,

    // TX A, writes and all other outbound traffic
    input  wire pcie_host_chan_pkg::host_beat_t     host_tx_a,
    input  wire logic                               host_tx_a_valid,
    output logic                                    host_tx_a_ready,
    output pcie_host_chan_pkg::pcie_ss_beat_t       ss_tx_a,
    output logic                                    ss_tx_a_valid,
    input  wire logic                               ss_tx_a_ready,

    // TX B, read requests
    input  wire pcie_host_chan_pkg::host_beat_t     host_tx_b,
    input  wire logic                               host_tx_b_valid,
    output logic                                    host_tx_b_ready,
    output pcie_host_chan_pkg::pcie_ss_beat_t       ss_tx_b,
    output logic                                    ss_tx_b_valid,
    input  wire logic                               ss_tx_b_ready,

    // RX A, host to FPGA traffic
    input  wire pcie_host_chan_pkg::pcie_ss_beat_t  ss_rx_a,
    input  wire logic                               ss_rx_a_valid,
    output logic                                    ss_rx_a_ready,
    output pcie_host_chan_pkg::host_beat_t          host_rx_a,
    output logic                                    host_rx_a_valid,
    input  wire logic                               host_rx_a_ready,

    // RX B, header-only write completions
    input  wire pcie_host_chan_pkg::pcie_ss_beat_t  ss_rx_b,
    input  wire logic                               ss_rx_b_valid,
    output logic                                    ss_rx_b_ready,
    output pcie_host_chan_pkg::host_beat_t          host_rx_b,
    output logic                                    host_rx_b_valid,
    input  wire logic                               host_rx_b_ready
);

    // TX A mapper
    host_chan_tx_map u_tx_a
    (
        .in_beat   (host_tx_a),
        .in_valid  (host_tx_a_valid),
        .in_ready  (host_tx_a_ready),
        .out_beat  (ss_tx_a),
        .out_valid (ss_tx_a_valid),
        .out_ready (ss_tx_a_ready)
    );

    // TX B uses the same mapping as TX A
    host_chan_tx_map u_tx_b
    (
        .in_beat   (host_tx_b),
        .in_valid  (host_tx_b_valid),
        .in_ready  (host_tx_b_ready),
        .out_beat  (ss_tx_b),
        .out_valid (ss_tx_b_valid),
        .out_ready (ss_tx_b_ready)
    );

    // RX A carries multi-beat packets, so sop has to be tracked
    host_chan_rx_map #(
        .CPL_ONLY (1'b0)
    ) u_rx_a (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (ss_rx_a),
        .in_valid  (ss_rx_a_valid),
        .in_ready  (ss_rx_a_ready),
        .out_beat  (host_rx_a),
        .out_valid (host_rx_a_valid),
        .out_ready (host_rx_a_ready)
    );

    // RX B completions are single beats, framed from last alone
    host_chan_rx_map #(
        .CPL_ONLY (1'b1)
    ) u_rx_b (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_beat   (ss_rx_b),
        .in_valid  (ss_rx_b_valid),
        .in_ready  (ss_rx_b_ready),
        .out_beat  (host_rx_b),
        .out_valid (host_rx_b_valid),
        .out_ready (host_rx_b_ready)
    );

endmodule

`default_nettype wire

// ==== test/pcie_host_chan_map_props.sv ====
/* Handshake and framing properties of the host channel adapter, bound to its top.
   Checks run every clock; the reset property looks at the first cycle after release. */
`timescale 1ns/100ps
`default_nettype none

module pcie_host_chan_map_props
(
    input wire logic                            clk,
    input wire logic                            reset_n,
    input wire logic                            host_tx_a_ready,
    input wire logic                            ss_tx_a_ready,
    input wire logic                            host_tx_b_ready,
    input wire logic                            ss_tx_b_ready,
    input wire logic                            ss_rx_a_ready,
    input wire logic                            host_rx_a_ready,
    input wire logic                            ss_rx_b_ready,
    input wire logic                            host_rx_b_ready,
    input wire pcie_host_chan_pkg::host_beat_t  host_rx_a,
    input wire pcie_host_chan_pkg::host_beat_t  host_rx_b,
    input wire logic                            host_rx_b_valid
);

    import pcie_host_chan_pkg::*;

    // Ready is a plain wire back to the source on every channel
    a_tx_ready: assert property (@(posedge clk)
        (host_tx_a_ready == ss_tx_a_ready) && (host_tx_b_ready == ss_tx_b_ready))
        else $error("TX ready does not follow the subsystem ready");

    a_rx_ready: assert property (@(posedge clk)
        (ss_rx_a_ready == host_rx_a_ready) && (ss_rx_b_ready == host_rx_b_ready))
        else $error("RX ready does not follow the platform ready");

    // A completion beat is a whole packet, so it starts and ends together
    a_cpl_frame: assert property (@(posedge clk) disable iff (!reset_n)
        host_rx_b_valid |-> (host_rx_b.user[0].sop == host_rx_b.user[0].eop))
        else $error("RX B sop and eop differ on a valid beat");

    // Reset leaves RX A at a packet boundary
    a_reset_sop: assert property (@(posedge clk) $rose(reset_n) |-> host_rx_a.user[0].sop)
        else $error("RX A sop is low right after reset");

endmodule

bind pcie_host_chan_map pcie_host_chan_map_props i_props
(
    .clk             (clk),
    .reset_n         (reset_n),
    .host_tx_a_ready (host_tx_a_ready),
    .ss_tx_a_ready   (ss_tx_a_ready),
    .host_tx_b_ready (host_tx_b_ready),
    .ss_tx_b_ready   (ss_tx_b_ready),
    .ss_rx_a_ready   (ss_rx_a_ready),
    .host_rx_a_ready (host_rx_a_ready),
    .ss_rx_b_ready   (ss_rx_b_ready),
    .host_rx_b_ready (host_rx_b_ready),
    .host_rx_a       (host_rx_a),
    .host_rx_b       (host_rx_b),
    .host_rx_b_valid (host_rx_b_valid)
);

`default_nettype wire

// ==== test/tb_pcie_host_chan_map.sv ====
/* Vector-driven testbench for the host channel adapter, read from the golden file.
   Data is expanded from one 32-bit word per vector; run from the project root. */
`timescale 1ns/100ps
`default_nettype none

module tb_pcie_host_chan_map;

    import pcie_host_chan_pkg::*;

    localparam int CLK_PERIOD    = 8;
    localparam int MAX_VECS      = 256;

    // One golden line, stimulus first and expected outputs after
    typedef struct packed {
        logic [7:0]  test;
        logic [1:0]  ch;
        logic        same;
        logic        rst;
        logic [31:0] word;
        logic [31:0] keep;
        logic        last;
        logic [9:0]  uin;
        logic        valid;
        logic        ready;
        logic [31:0] ekeep;
        logic        elast;
        logic [9:0]  euser;
        logic        evalid;
        logic        eready;
    } vec_t;

    logic clk;
    logic reset_n;
    host_beat_t    host_tx_a, host_tx_b, host_rx_a, host_rx_b;
    pcie_ss_beat_t ss_tx_a, ss_tx_b, ss_rx_a, ss_rx_b;
    logic host_tx_a_valid, host_tx_a_ready, ss_tx_a_valid, ss_tx_a_ready;
    logic host_tx_b_valid, host_tx_b_ready, ss_tx_b_valid, ss_tx_b_ready;
    logic ss_rx_a_valid, ss_rx_a_ready, host_rx_a_valid, host_rx_a_ready;
    logic ss_rx_b_valid, ss_rx_b_ready, host_rx_b_valid, host_rx_b_ready;

    vec_t vecs [MAX_VECS];
    int num_vecs;
    int errors;
    int checks;
    int test_errors;
    int test_checks;
    int tests_done;
    logic [7:0] cur_test;

    pcie_host_chan_map i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog in case anything stalls the main sequence
    initial
    begin
        #(CLK_PERIOD * 2000);
        $display("timeout: the vector run did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    // Every 32-bit dword of the beat differs, so lane swaps show up
    function automatic logic [255:0] expand_data(input logic [31:0] w);
        logic [255:0] d;
        for (int i = 0; i < 8; i++)
        begin
            d[i*32 +: 32] = w ^ (i * 32'h01010101);
        end
        return d;
    endfunction

    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] t_test, t_ch, t_same, t_rst, t_word, t_keep, t_last, t_uin;
        logic [31:0] t_valid, t_ready, t_ekeep, t_elast, t_euser, t_evalid, t_eready;
        num_vecs = 0;
        fd = $fopen("test/pcie_host_chan_map_golden.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the golden vector file");
            errors++;
            return;
        end
        while (!$feof(fd) && num_vecs < MAX_VECS)
        begin
            n = $fgets(line, fd);
            // Column notes and blank lines carry no vector
            if (n < 3 || line.substr(0, 0) == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        t_test, t_ch, t_same, t_rst, t_word, t_keep, t_last, t_uin,
                        t_valid, t_ready, t_ekeep, t_elast, t_euser, t_evalid, t_eready);
            if (n != 15)
            begin
                $display("malformed vector line: %s", line);
                errors++;
                continue;
            end
            vecs[num_vecs] = {t_test[7:0], t_ch[1:0], t_same[0], t_rst[0], t_word,
                              t_keep, t_last[0], t_uin[9:0], t_valid[0], t_ready[0],
                              t_ekeep, t_elast[0], t_euser[9:0], t_evalid[0], t_eready[0]};
            num_vecs++;
        end
        $fclose(fd);
        if (num_vecs == 0)
        begin
            $display("no vectors were read from the golden file");
            errors++;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        test_checks++;
        assert (got === exp)
        else
        begin
            $display("mismatch %s: expected %0h, got %0h", name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_data(input string name, input logic [255:0] exp, input logic [255:0] got);
        checks++;
        test_checks++;
        assert (got === exp)
        else
        begin
            $display("mismatch %s: expected %0h, got %0h", name, exp, got);
            errors++;
            test_errors++;
        end
    endtask

    // Drives one channel only; the others keep what they last had
    task automatic drive_vec(input vec_t v);
        host_beat_t    hb;
        pcie_ss_beat_t sb;
        hb.data = expand_data(v.word);
        hb.keep = v.keep;
        hb.last = v.last;
        hb.user = v.uin[5:0];
        sb.data = expand_data(v.word);
        sb.keep = v.keep;
        sb.last = v.last;
        sb.user_vendor = v.uin;
        case (v.ch)
            2'd0:
            begin
                host_tx_a = hb;
                host_tx_a_valid = v.valid;
                ss_tx_a_ready = v.ready;
            end
            2'd1:
            begin
                host_tx_b = hb;
                host_tx_b_valid = v.valid;
                ss_tx_b_ready = v.ready;
            end
            2'd2:
            begin
                ss_rx_a = sb;
                ss_rx_a_valid = v.valid;
                host_rx_a_ready = v.ready;
            end
            default:
            begin
                ss_rx_b = sb;
                ss_rx_b_valid = v.valid;
                host_rx_b_ready = v.ready;
            end
        endcase
    endtask

    task automatic check_vec(input vec_t v);
        pcie_ss_beat_t sb;
        host_beat_t    hb;
        logic          ovalid;
        logic          iready;
        string         pfx;
        if (v.ch < 2'd2)
        begin
            sb     = (v.ch == 2'd0) ? ss_tx_a : ss_tx_b;
            ovalid = (v.ch == 2'd0) ? ss_tx_a_valid : ss_tx_b_valid;
            iready = (v.ch == 2'd0) ? host_tx_a_ready : host_tx_b_ready;
            pfx    = (v.ch == 2'd0) ? "ss_tx_a" : "ss_tx_b";
            check_data({pfx, ".data"}, expand_data(v.word), sb.data);
            check_val({pfx, ".keep"}, v.ekeep, sb.keep);
            check_val({pfx, ".last"}, 32'(v.elast), 32'(sb.last));
            check_val({pfx, ".user_vendor"}, 32'(v.euser), 32'(sb.user_vendor));
        end
        else
        begin
            hb     = (v.ch == 2'd2) ? host_rx_a : host_rx_b;
            ovalid = (v.ch == 2'd2) ? host_rx_a_valid : host_rx_b_valid;
            iready = (v.ch == 2'd2) ? ss_rx_a_ready : ss_rx_b_ready;
            pfx    = (v.ch == 2'd2) ? "host_rx_a" : "host_rx_b";
            check_data({pfx, ".data"}, expand_data(v.word), hb.data);
            check_val({pfx, ".keep"}, v.ekeep, hb.keep);
            check_val({pfx, ".last"}, 32'(v.elast), 32'(hb.last));
            check_val({pfx, ".user"}, 32'(v.euser[5:0]), 32'(hb.user));
        end
        check_val({pfx, "_valid"}, 32'(v.evalid), 32'(ovalid));
        check_val({pfx, " upstream ready"}, 32'(v.eready), 32'(iready));
    endtask

    task automatic report_test();
        if (cur_test != 8'd0)
        begin
            $display("test %0d: %0d checks, %0d errors", cur_test, test_checks, test_errors);
            tests_done++;
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial
    begin
        int i;
        int last_idx;
        errors = 0;
        checks = 0;
        tests_done = 0;
        cur_test = 8'd0;
        reset_n = 1'b0;
        host_tx_a = '0;
        host_tx_b = '0;
        ss_rx_a = '0;
        ss_rx_b = '0;
        {host_tx_a_valid, ss_tx_a_ready, host_tx_b_valid, ss_tx_b_ready} = '0;
        {ss_rx_a_valid, host_rx_a_ready, ss_rx_b_valid, host_rx_b_ready} = '0;
        load_vectors();

        // Hold reset for three cycles and release it just after an edge
        repeat (3) @(posedge clk);
        #1;
        reset_n = 1'b1;

        i = 0;
        while (i < num_vecs)
        begin
            // Lines flagged same are applied together in one cycle
            last_idx = i;
            while (last_idx + 1 < num_vecs && vecs[last_idx+1].same)
                last_idx++;
            if (vecs[i].test != cur_test)
            begin
                report_test();
                cur_test = vecs[i].test;
            end
            reset_n = vecs[i].rst;
            for (int k = i; k <= last_idx; k++)
                drive_vec(vecs[k]);
            // Sample one ns before the next edge, when all outputs have settled
            #(CLK_PERIOD - 2);
            for (int k = i; k <= last_idx; k++)
                check_vec(vecs[k]);
            @(posedge clk);
            #1;
            i = last_idx + 1;
        end
        report_test();

        $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pcie_host_chan_map.f ====
src/pcie_host_chan_pkg.sv
src/host_chan_tx_map.sv
src/host_chan_rx_map.sv
src/pcie_host_chan_map.sv
test/pcie_host_chan_map_props.sv
test/tb_pcie_host_chan_map.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_pcie_host_chan_map
FILELIST  = pcie_host_chan_map.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/pcie_host_chan_map_golden.txt ====
# test ch same rst word keep last user valid ready | exp: keep last user valid ready
# ch 0 TX A, 1 TX B, 2 RX A, 3 RX B; same 1 shares the previous line's cycle; all hex
1 0 0 1 a5a50001 ffffffff 1 004 1 1 ffffffff 1 001 1 1
1 0 0 1 a5a50002 00000001 0 000 1 1 0000000f 0 000 1 1
1 0 0 1 a5a50003 12345678 0 03b 1 1 f0f0f0f0 0 000 1 1
1 0 0 1 a5a50004 0000000e 1 007 1 1 00000000 1 001 1 1
1 0 0 1 a5a50005 0000ff00 0 020 0 1 0000ff00 0 000 0 1
2 0 0 1 11110000 000000ff 1 004 1 1 000000ff 1 001 1 1
2 1 1 1 22220000 0000f00f 0 000 1 0 0000f00f 0 000 1 0
2 0 0 1 33330000 11110000 0 000 1 0 ffff0000 0 000 1 0
2 1 1 1 44440000 fffffff1 1 024 1 1 ffffffff 1 001 1 1
3 2 0 1 c0000001 ffffffff 0 001 1 1 ffffffff 0 006 1 1
3 2 0 1 c0000002 ffffffff 0 001 1 1 ffffffff 0 004 1 1
3 2 0 1 c0000003 0000ffff 1 001 1 1 0000ffff 1 005 1 1
3 2 0 1 c0000004 000000ff 1 000 1 1 000000ff 1 003 1 1
3 2 0 1 c0000005 ffffffff 0 3fe 1 1 ffffffff 0 002 1 1
3 2 0 1 c0000006 00010000 1 3fe 1 1 00010000 1 001 1 1
3 2 0 1 c0000007 00000000 0 000 0 1 00000000 0 002 0 1
4 2 0 1 d0000001 ffffffff 0 001 1 1 ffffffff 0 006 1 1
4 2 0 1 d0000002 ffffffff 1 001 1 0 ffffffff 1 005 1 0
4 2 0 1 d0000002 ffffffff 1 001 1 0 ffffffff 1 005 1 0
4 2 0 1 d0000002 ffffffff 1 001 1 0 ffffffff 1 005 1 0
4 2 0 1 d0000002 ffffffff 1 001 1 1 ffffffff 1 005 1 1
4 2 0 1 d0000003 00000000 1 000 1 1 00000000 1 002 1 1
4 2 0 1 d0000004 fffefffe 1 000 1 1 fffefffe 1 002 1 1
5 3 0 1 e0000001 ffffffff 1 001 1 1 ffffffff 1 007 1 1
5 3 0 1 e0000002 0000000f 0 000 1 1 0000000f 0 000 1 1
5 3 0 1 e0000003 00000000 1 3fe 1 0 00000000 1 003 1 0
5 3 0 1 e0000004 ffff0000 0 3ff 0 1 ffff0000 0 004 0 1
6 2 0 1 f0000001 ffffffff 0 000 1 1 ffffffff 0 002 1 1
6 2 0 1 f0000002 ffffffff 0 000 1 1 ffffffff 0 000 1 1
6 2 0 0 f0000003 ffffffff 0 000 0 1 ffffffff 0 000 0 1
6 2 0 1 f0000004 ffffffff 0 000 1 1 ffffffff 0 002 1 1
